/* design/ahb_arbiter.sv */
module ahb_arbiter (
	input  logic HCLK,
	input  logic HRESETn,

	input  logic HBUSREQ,
	input  logic HLOCK,
	input  logic HREADY,
	input  logic ext_busreq,

	output logic HGRANT,
	output logic ext_grant
);

	logic owner_req;
	logic other_req;
	logic handover;

	assign owner_req = ext_grant ? ext_busreq : HBUSREQ;
	assign other_req = ext_grant ? HBUSREQ : ext_busreq;

	// Owner keeps the bus while it asks and the other side goes next
	assign handover = HREADY && !(HGRANT && HLOCK) && !owner_req && other_req;

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			HGRANT    <= 1'b1; // Parked on the line master
			ext_grant <= 1'b0;
		end else if (handover) begin
			HGRANT    <= !HGRANT;
			ext_grant <= !ext_grant;
		end
	end

	a_one_grant: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!(HGRANT && ext_grant));

endmodule

/* design/ahb_line_master.sv */
module ahb_line_master import ahb_pkg::*; (
	input  logic        HCLK,
	input  logic        HRESETn,

	line_bus_if.master  bus,

	output logic        HBUSREQ,
	output logic        HLOCK,
	input  logic        HGRANT,

	output logic [1:0]  HTRANS,
	output logic        HWRITE,
	output logic [2:0]  HSIZE,
	output logic [2:0]  HBURST,
	output logic [31:0] HADDR,
	output logic [31:0] HWDATA,

	input  logic        HREADY,
	input  logic [1:0]  HRESP,
	input  logic [31:0] HRDATA
);

	logic [2:0]           state;
	logic [2:0]           next_state;
	logic [BEAT_BITS-1:0] beat;
	logic                 last_addr; // Final SEQ accepted
	ahb_addr_t            beat_addr;

	assign last_addr = (state == ST_RCONT) && HREADY && (beat == LINE_BEATS - 1);

	// Line base from the request with the beat index below it
	always_comb begin
		beat_addr.f.line = bus.addr.f.line;
		beat_addr.f.beat = beat;
		beat_addr.f.ofs  = 2'b00;
	end

	assign bus.take = HREADY && (state == ST_RADDR || state == ST_WADDR);

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			HBUSREQ <= 1'b0;
			HLOCK   <= 1'b0;
		end else if (state == ST_IDLE && bus.start && !HBUSREQ) begin
			HBUSREQ <= 1'b1;
			HLOCK   <= !bus.write; // Only line reads are locked
		end else if (last_addr || (state == ST_WADDR && HREADY)) begin
			HBUSREQ <= 1'b0;
			HLOCK   <= 1'b0;
		end
	end

	always_ff @(posedge HCLK) begin
		if (!HRESETn)
			beat <= '0;
		else if (state == ST_IDLE)
			beat <= '0;
		else if (HREADY && (state == ST_RADDR || state == ST_RCONT))
			beat <= beat + 1'b1;
	end

	always_ff @(posedge HCLK) begin
		if (!HRESETn)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE:
				if (HBUSREQ && HGRANT && HREADY)
					next_state = bus.write ? ST_WADDR : ST_RADDR;
			ST_RADDR: if (HREADY) next_state = ST_RCONT;
			ST_RCONT: if (last_addr) next_state = ST_RFIN;
			ST_RFIN:  if (HREADY) next_state = ST_IDLE;
			ST_WADDR: if (HREADY) next_state = ST_WDATA;
			ST_WDATA: if (HREADY) next_state = ST_IDLE;
			default:  next_state = ST_IDLE;
		endcase
	end

	always_comb begin
		HTRANS = TRN_IDLE;
		HWRITE = 1'b0;
		HSIZE  = SIZ_WORD;
		HBURST = BUR_SINGLE;
		HADDR  = '0;
		HWDATA = '0;
		case (state)
			ST_RADDR: begin
				HTRANS = TRN_NONSEQ;
				HBURST = BUR_INCR16;
				HADDR  = beat_addr.raw;
			end
			ST_RCONT: begin
				HTRANS = TRN_SEQ;
				HBURST = BUR_INCR16;
				HADDR  = beat_addr.raw;
			end
			ST_WADDR: begin
				HTRANS = TRN_NONSEQ;
				HWRITE = 1'b1;
				HADDR  = bus.addr.raw;
			end
			ST_WDATA: HWDATA = bus.wdata;
			default: ;
		endcase
	end

	// Completed read data phases appear one cycle late
	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			bus.beat_valid <= 1'b0;
			bus.beat_last  <= 1'b0;
		end else begin
			bus.beat_valid <= HREADY && (state == ST_RCONT || state == ST_RFIN);
			bus.beat_last  <= HREADY && (state == ST_RFIN || state == ST_WDATA);
		end
	end

	always_ff @(posedge HCLK) begin
		bus.beat_data <= HRDATA;
	end

	a_seq_step: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(HTRANS != TRN_IDLE && HREADY) ##1 (HTRANS == TRN_SEQ) |->
			HADDR == $past(HADDR) + 32'd4 &&
			HADDR / LINE_BYTES == $past(HADDR) / LINE_BYTES);

	a_resp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
		HREADY |-> HRESP == RSP_OKAY);

endmodule

/* design/ahb_pkg.sv */
package ahb_pkg;

	// HTRANS, HRESP, HSIZE and HBURST codes
	localparam logic [1:0] TRN_IDLE   = 2'b00;
	localparam logic [1:0] TRN_NONSEQ = 2'b10;
	localparam logic [1:0] TRN_SEQ    = 2'b11;
	localparam logic [1:0] RSP_OKAY   = 2'b00;
	localparam logic [2:0] SIZ_WORD   = 3'b010;
	localparam logic [2:0] BUR_SINGLE = 3'b000;
	localparam logic [2:0] BUR_INCR16 = 3'b111;

	localparam int LINE_BEATS = 16;
	localparam int BEAT_BITS  = 4;
	localparam int LINE_BYTES = 64;

	localparam int CREDIT_MAX = 16; // Also the credits a read needs to start

	localparam int MEM_WORDS = 256;
	localparam int MEM_BITS  = $clog2(MEM_WORDS);

	// Line master FSM
	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_RADDR = 3'd1;
	localparam logic [2:0] ST_RCONT = 3'd2;
	localparam logic [2:0] ST_RFIN  = 3'd3;
	localparam logic [2:0] ST_WADDR = 3'd4;
	localparam logic [2:0] ST_WDATA = 3'd5;

	// Byte address as raw word or as line, beat and byte
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [31-BEAT_BITS-2:0] line;
			logic [BEAT_BITS-1:0]    beat;
			logic [1:0]              ofs;
		} f;
	} ahb_addr_t;

endpackage

/* design/ahb_sram_slave.sv */
module ahb_sram_slave import ahb_pkg::*; (
	input  logic        HCLK,
	input  logic        HRESETn,

	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic [31:0] HADDR,
	input  logic [31:0] HWDATA,

	output logic        HREADY,
	output logic [1:0]  HRESP,
	output logic [31:0] HRDATA
);

	logic [31:0]         mem [MEM_WORDS];
	ahb_addr_t           haddr_w;
	logic [29:0]         word_idx;
	logic                addr_ok;  // Address phase accepted this cycle
	logic                dp_active;
	logic                dp_write;
	logic                wait_pend;
	logic [MEM_BITS-1:0] dp_idx;
	logic [6:0]          lfsr;

	assign haddr_w  = HADDR;
	assign word_idx = {haddr_w.f.line, haddr_w.f.beat};
	assign addr_ok  = HREADY && (HTRANS == TRN_NONSEQ || HTRANS == TRN_SEQ);

	assign HREADY = !wait_pend;
	assign HRESP  = RSP_OKAY;
	assign HRDATA = dp_active ? mem[dp_idx] : '0;

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			dp_active <= 1'b0;
			dp_write  <= 1'b0;
			wait_pend <= 1'b0;
			lfsr      <= 7'h5b;
		end else begin
			lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
			if (HREADY) begin
				dp_active <= addr_ok;
				dp_write  <= addr_ok && HWRITE;
				wait_pend <= addr_ok && lfsr[0]; // At most one wait per phase
			end else begin
				wait_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge HCLK) begin
		if (addr_ok)
			dp_idx <= word_idx[MEM_BITS-1:0]; // Wraps modulo depth
		if (HREADY && dp_active && dp_write)
			mem[dp_idx] <= HWDATA;
	end

	a_word_size: assert property (@(posedge HCLK) disable iff (!HRESETn)
		addr_ok |-> HSIZE == SIZ_WORD);

endmodule

/* design/line_bus_if.sv */
interface line_bus_if import ahb_pkg::*; ();

	// Port to master
	logic        start;
	logic        write;
	ahb_addr_t   addr;
	logic [31:0] wdata;

	// Master to port
	logic        take;
	logic        beat_valid;
	logic [31:0] beat_data;
	logic        beat_last; // Alone it ends a write

	modport port (
		output start, write, addr, wdata,
		input  take, beat_valid, beat_data, beat_last
	);

	modport master (
		input  start, write, addr, wdata,
		output take, beat_valid, beat_data, beat_last
	);

endinterface

/* design/line_fill_top.sv */
module line_fill_top (
	input  logic        HCLK,
	input  logic        HRESETn,

	input  logic        req_valid,
	input  logic        req_write,
	input  logic [31:0] req_addr,
	input  logic [31:0] req_wdata,
	output logic        req_ready,

	output logic        rsp_valid,
	output logic [31:0] rsp_data,
	output logic        rsp_last,
	input  logic        rsp_credit,

	input  logic        ext_busreq,
	output logic        ext_grant
);

	logic        HBUSREQ;
	logic        HLOCK;
	logic        HGRANT;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic [2:0]  HBURST;
	logic [31:0] HADDR;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [1:0]  HRESP;
	logic [31:0] HRDATA;

	line_bus_if bus_i ();

	line_req_port line_req_port_i (
		.HCLK, .HRESETn,
		.req_valid, .req_write, .req_addr, .req_wdata, .req_ready,
		.rsp_valid, .rsp_data, .rsp_last, .rsp_credit,
		.bus(bus_i)
	);

	ahb_line_master ahb_line_master_i (
		.HCLK, .HRESETn,
		.bus(bus_i),
		.HBUSREQ, .HLOCK, .HGRANT,
		.HTRANS, .HWRITE, .HSIZE, .HBURST, .HADDR, .HWDATA,
		.HREADY, .HRESP, .HRDATA
	);

	ahb_arbiter ahb_arbiter_i (
		.HCLK, .HRESETn,
		.HBUSREQ, .HLOCK, .HREADY,
		.ext_busreq,
		.HGRANT, .ext_grant
	);

	ahb_sram_slave ahb_sram_slave_i (
		.HCLK, .HRESETn,
		.HTRANS, .HWRITE, .HSIZE, .HADDR, .HWDATA,
		.HREADY, .HRESP, .HRDATA
	);

endmodule

/* design/line_req_port.sv */
module line_req_port import ahb_pkg::*; (
	input  logic        HCLK,
	input  logic        HRESETn,

	input  logic        req_valid,
	input  logic        req_write,
	input  logic [31:0] req_addr,
	input  logic [31:0] req_wdata,
	output logic        req_ready,

	output logic        rsp_valid,
	output logic [31:0] rsp_data,
	output logic        rsp_last,
	input  logic        rsp_credit,

	line_bus_if.port    bus
);

	logic        held;     // A request is pending or in flight
	logic        launched; // Master has taken it
	logic        pend_write;
	ahb_addr_t   pend_addr;
	logic [31:0] pend_wdata;
	logic [4:0]  credits;
	logic        credits_full;

	assign credits_full = (credits == CREDIT_MAX);
	assign req_ready = !held;

	// Reads wait for a whole line of credits
	assign bus.start = held && !launched && (pend_write || credits_full);
	assign bus.write = pend_write;
	assign bus.addr  = pend_addr;
	assign bus.wdata = pend_wdata;

	assign rsp_valid = bus.beat_valid;
	assign rsp_data  = bus.beat_data;
	assign rsp_last  = bus.beat_valid && bus.beat_last;

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			held     <= 1'b0;
			launched <= 1'b0;
		end else if (req_valid && req_ready) begin
			held     <= 1'b1;
			launched <= 1'b0;
		end else begin
			if (bus.take)
				launched <= 1'b1;
			if (bus.beat_last) begin // End of line or write done
				held     <= 1'b0;
				launched <= 1'b0;
			end
		end
	end

	always_ff @(posedge HCLK) begin
		if (req_valid && req_ready) begin
			pend_write <= req_write;
			pend_addr  <= req_addr;
			pend_wdata <= req_wdata;
		end
	end

	always_ff @(posedge HCLK) begin
		if (!HRESETn)
			credits <= 5'(CREDIT_MAX);
		else
			credits <= credits + {4'd0, rsp_credit} - {4'd0, bus.beat_valid};
	end

	a_credit_range: assert property (@(posedge HCLK) disable iff (!HRESETn)
		credits <= CREDIT_MAX && !(credits == 5'd0 && bus.beat_valid && !rsp_credit));

endmodule

/* files.f */
design/ahb_pkg.sv
design/line_bus_if.sv
design/line_req_port.sv
design/ahb_line_master.sv
design/ahb_arbiter.sv
design/ahb_sram_slave.sv
design/line_fill_top.sv
tests/line_fill_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module line_fill_tb \
	-o line_fill_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/line_fill_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log || exit 1
exit 0

/* tests/line_fill_tb.sv */
module line_fill_tb import ahb_pkg::*; ();

	localparam int WAIT_LIMIT = 300;
	localparam int READ_LIMIT = 400;

	logic        HCLK;
	logic        HRESETn;
	logic        req_valid;
	logic        req_write;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic        req_ready;
	logic        rsp_valid;
	logic [31:0] rsp_data;
	logic        rsp_last;
	logic        rsp_credit;
	logic        ext_busreq;
	logic        ext_grant;

	logic [31:0] shadow [MEM_WORDS];
	logic        rand_line [16]; // Lines holding random words
	int          errors;
	int          pass_cnt;
	int          fail_cnt;
	int          owed;      // Beats absorbed but not yet credited back
	int          hold_cnt;
	int          ext_cnt;
	logic        full_seen; // Credits back at the limit since the last accept
	logic        aborted;
	integer      seed;

	line_fill_top line_fill_top_i (.*);

	initial begin
		HCLK = 1'b0;
		forever #2 HCLK = ~HCLK;
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Advance one clock and sample before driving
	task automatic step();
		@(negedge HCLK);
		if (ext_grant && line_fill_top_i.HTRANS != TRN_IDLE) begin
			$display("Master transfer seen while the external requester held the bus");
			errors++;
		end
		if (rsp_valid)
			owed++;
		if (hold_cnt > 0) begin
			hold_cnt--;
			rsp_credit = 1'b0;
		end else if (owed > 0) begin
			rsp_credit = 1'b1;
			owed--;
		end else begin
			rsp_credit = 1'b0;
		end
		if (owed == 0)
			full_seen = 1'b1;
		ext_busreq = (ext_cnt > 0);
		if (ext_cnt > 0)
			ext_cnt--;
	endtask

	task automatic wait_ready(input string name);
		int t;
		t = 0;
		while (!req_ready && t < WAIT_LIMIT) begin
			step();
			t++;
		end
		if (!req_ready) begin
			$display("Timeout: request port never became ready in %s", name);
			aborted = 1'b1;
		end
	endtask

	task automatic write_word(input logic [31:0] a, input logic [31:0] d, input string name);
		wait_ready(name);
		if (aborted)
			return;
		req_valid = 1'b1;
		req_write = 1'b1;
		req_addr  = a;
		req_wdata = d;
		step();
		req_valid = 1'b0;
		shadow[a[9:2]] = d;
		wait_ready(name); // Back high once the data phase is done
	endtask

	task automatic read_line(input logic [31:0] a, input logic [31:0] xor_exp, input string name);
		int          t;
		int          k;
		logic [31:0] acc;
		logic [7:0]  base;
		logic        got_last;
		wait_ready(name);
		if (aborted)
			return;
		req_valid = 1'b1;
		req_write = 1'b0;
		req_addr  = a;
		full_seen = (owed == 0);
		step();
		req_valid = 1'b0;
		base = {a[9:6], 4'h0};
		k = 0;
		t = 0;
		acc = '0;
		got_last = 1'b0;
		while (!got_last && t < READ_LIMIT) begin
			if (rsp_valid) begin
				if (!full_seen) begin
					$display("Beat returned in %s while credits were short", name);
					errors++;
				end
				check_value($sformatf("%s beat %0d", name, k), shadow[8'(base + k)], rsp_data);
				check_value($sformatf("%s last %0d", name, k), 32'(k == 15), 32'(rsp_last));
				acc ^= rsp_data;
				got_last = rsp_last;
				k++;
			end else if (req_ready) begin
				$display("Request port ready again in %s before the line ended", name);
				errors++;
			end
			if (!got_last) begin
				step();
				t++;
			end
		end
		if (!got_last) begin
			$display("Timeout: line never completed in %s", name);
			aborted = 1'b1;
			return;
		end
		check_value({name, " beat count"}, 32'd16, 32'(k));
		step();
		check_value({name, " ready after last"}, 32'd1, 32'(req_ready));
		if (!rand_line[a[9:6]])
			check_value({name, " xor"}, xor_exp, acc);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errors == errs_before && !aborted) begin
			pass_cnt++;
			$display("ok   %s", name);
		end else begin
			fail_cnt++;
			$display("bad  %s", name);
		end
	endtask

	initial begin
		integer      fd;
		int          n;
		int          t;
		int          errs;
		logic [7:0]  op;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] w;
		string       skip;
		string       name;
		HRESETn = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		rsp_credit = 1'b0;
		ext_busreq = 1'b0;
		errors = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		owed = 0;
		hold_cnt = 0;
		ext_cnt = 0;
		full_seen = 1'b1;
		aborted = 1'b0;
		seed = 89495;
		for (int i = 0; i < 16; i++)
			rand_line[i] = 1'b0;
		repeat (16) @(negedge HCLK);
		HRESETn = 1'b1;
		step();

		// Pattern from the word index makes a clean line XOR to 0000ffff
		errs = errors;
		for (int i = 0; i < MEM_WORDS && !aborted; i++)
			write_word(32'(i) << 2, {8'(i), 8'h00, 16'h0001 << i[3:0]}, "preload");
		finish_test("preload", errs);

		fd = $fopen("tests/line_fill_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file");
			aborted = 1'b1;
		end
		while (!aborted && $fscanf(fd, " %c", op) == 1) begin
			if (op == "#") begin
				n = $fgets(skip, fd);
				continue;
			end
			errs = errors;
			f2 = '0;
			if (op == "W" || op == "R")
				n = $fscanf(fd, "%h %h", f1, f2) - 2;
			else
				n = $fscanf(fd, "%h", f1) - 1;
			if (n != 0) begin
				$display("Missing fields in trace operation %c", op);
				errors++;
			end
			name = $sformatf("%c %h %h", op, f1, f2);
			case (op)
				"W": write_word(f1, f2, name);
				"R": read_line(f1, f2, name);
				"F": begin
					for (int k = 0; k < 16 && !aborted; k++) begin
						w = $random(seed);
						write_word({f1[31:6], 4'(k), 2'b00}, w, name);
					end
					rand_line[f1[9:6]] = 1'b1;
				end
				"H": hold_cnt = f1;
				"X": begin
					ext_cnt = f1;
					t = 0;
					while (!ext_grant && t < WAIT_LIMIT) begin
						step();
						t++;
					end
					if (!ext_grant) begin
						$display("Timeout: external grant never rose in %s", name);
						aborted = 1'b1;
					end
				end
				default: begin
					$display("Unknown trace operation %c", op);
					errors++;
				end
			endcase
			finish_test(name, errs);
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && !aborted && errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tests/line_fill_trace.txt */
# op  field1    field2, all fields hex
# W addr data | F line | R addr xor (xor unchecked on F lines) | H cycles | X cycles
W 00000104 deadbeef
W 00000110 12345678
R 00000100 c999177a
F 00000200
R 00000200 00000000
W 00000208 00c0ffee
R 00000200 00000000
# Withheld credits stall the second read
H 00000078
R 00000300 0000ffff
R 000003c0 0000ffff
# External requester owns the bus
X 00000028
W 00000180 cafef00d
R 00000180 aafe0ff3
X 0000001e
R 00000100 c999177a
# Unaligned read and a neighbor line
R 00000128 c999177a
W 00000130 0badf00d
R 00000140 0000ffff
R 00000100 8e34f777
